//--- hw/pci_pkg.sv
package pci_pkg;

	// C/BE# codes seen during the address phase
	typedef enum logic [3:0]
	{
		CMD_MEM_READ  = 4'b0110,
		CMD_MEM_WRITE = 4'b0111
	} pci_cmd_t;

	// memory space bases, 16 byte windows
	localparam logic [31:0] FN0_BASE = 32'hC000_0000;
	localparam logic [31:0] FN1_BASE = 32'hC000_0010;

	// register file per function
	localparam int REG_WORDS = 4;
	localparam int REG_IDX_W = $clog2(REG_WORDS);
	localparam int REG_IDX_LSB = 2; // dword aligned

	// first address bit that takes part in the base compare
	localparam int DEC_LSB = REG_IDX_LSB + REG_IDX_W;

	// even parity over AD and C/BE#
	function automatic logic pci_parity(
		input logic [31:0] ad,
		input logic [3:0] cbe_n
	);
		logic par;
		par = ^ad;
		par = par ^ (^cbe_n);
		return par;
	endfunction

endpackage

//--- hw/pci_drive_if.sv
interface pci_drive_if;

	logic [31:0] ad; // read data
	logic ad_oe;

	// target control values, active low
	logic trdy_n;
	logic stop_n;
	logic devsel_n;

	logic ctl_oe; // one enable for all three

	modport fn (
		output ad,
		output ad_oe,
		output trdy_n,
		output stop_n,
		output devsel_n,
		output ctl_oe
	);

	modport merge (
		input ad,
		input ad_oe,
		input trdy_n,
		input stop_n,
		input devsel_n,
		input ctl_oe
	);

endinterface

//--- hw/pci_target_fn.sv
module pci_target_fn #(
	parameter logic [31:0] BASE = pci_pkg::FN0_BASE
) (
	input logic CLK,
	input logic rstf,
	input logic [31:0] ad_i,
	input logic [3:0] cbe_n_i,
	input logic frame_n_i,
	input logic irdy_n_i,
	pci_drive_if.fn drv
);
	import pci_pkg::*;

	typedef enum logic [2:0]
	{
		S_IDLE,
		S_CLAIM,
		S_DATA,
		S_HOLD,
		S_TURN
	} state_t;

	state_t state_q;
	state_t state_d;

	logic frame_q; // frame_n_i at the previous edge
	logic addr_phase;
	pci_cmd_t cmd;
	logic cmd_ok;
	logic base_hit;
	logic hit;

	logic [REG_IDX_W-1:0] idx_q;
	logic wr_q;
	logic xfer;
	logic wr_en;
	logic rd_load;

	logic ad_oe_q;
	logic ad_oe_d;
	logic trdy_q;
	logic trdy_d;
	logic stop_q;
	logic stop_d;
	logic devsel_q;
	logic devsel_d;
	logic ctl_oe_q;
	logic ctl_oe_d;
	logic [31:0] ad_q;

	logic [31:0] regs [REG_WORDS];

	// address phase decode
	assign addr_phase = frame_q & ~frame_n_i;
	assign cmd = pci_cmd_t'(cbe_n_i);
	assign cmd_ok = (cmd == CMD_MEM_READ) || (cmd == CMD_MEM_WRITE);
	assign base_hit = (ad_i[31:DEC_LSB] == BASE[31:DEC_LSB]);
	assign hit = addr_phase && cmd_ok && base_hit;

	assign xfer = (state_q == S_DATA) && !irdy_n_i; // first data phase completes
	assign wr_en = xfer && wr_q;
	assign rd_load = (state_q == S_CLAIM) && !wr_q;

	always_comb
	begin
		state_d = state_q;
		ad_oe_d = ad_oe_q;
		trdy_d = trdy_q;
		stop_d = stop_q;
		devsel_d = devsel_q;
		ctl_oe_d = ctl_oe_q;
		case (state_q)
			S_IDLE:
			begin
				if (hit)
					state_d = S_CLAIM;
			end
			S_CLAIM:
			begin
				state_d = S_DATA;
				devsel_d = 1'b0;
				trdy_d = 1'b0;
				ctl_oe_d = 1'b1;
				ad_oe_d = !wr_q;
				stop_d = frame_n_i; // frame still low means a burst
			end
			S_DATA:
			begin
				if (!irdy_n_i)
				begin
					trdy_d = 1'b1;
					ad_oe_d = 1'b0;
					if (!stop_q && !frame_n_i)
						state_d = S_HOLD;
					else
					begin
						devsel_d = 1'b1;
						stop_d = 1'b1;
						state_d = S_TURN;
					end
				end
			end
			S_HOLD:
			begin
				// wait for the master to drop the burst
				if (frame_n_i)
				begin
					devsel_d = 1'b1;
					stop_d = 1'b1;
					state_d = S_TURN;
				end
			end
			S_TURN:
			begin
				ctl_oe_d = 1'b0; // released after one high cycle
				state_d = S_IDLE;
			end
			default:
			begin
				state_d = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge rstf)
	begin
		if (!rstf)
		begin
			state_q <= S_IDLE;
			frame_q <= 1'b1;
			idx_q <= '0;
			wr_q <= 1'b0;
			ad_oe_q <= 1'b0;
			trdy_q <= 1'b1;
			stop_q <= 1'b1;
			devsel_q <= 1'b1;
			ctl_oe_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			frame_q <= frame_n_i;
			ad_oe_q <= ad_oe_d;
			trdy_q <= trdy_d;
			stop_q <= stop_d;
			devsel_q <= devsel_d;
			ctl_oe_q <= ctl_oe_d;
			if ((state_q == S_IDLE) && hit)
			begin
				idx_q <= ad_i[REG_IDX_LSB +: REG_IDX_W];
				wr_q <= (cmd == CMD_MEM_WRITE);
			end
		end
	end

	// register file, byte writes
	always_ff @(posedge CLK or negedge rstf)
	begin
		if (!rstf)
			regs <= '{default: '0};
		else if (wr_en)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (!cbe_n_i[b])
					regs[idx_q][8*b +: 8] <= ad_i[8*b +: 8];
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (rd_load)
			ad_q <= regs[idx_q]; // full word on reads
	end

	assign drv.ad = ad_q;
	assign drv.ad_oe = ad_oe_q;
	assign drv.trdy_n = trdy_q;
	assign drv.stop_n = stop_q;
	assign drv.devsel_n = devsel_q;
	assign drv.ctl_oe = ctl_oe_q;

endmodule

//--- hw/pci_drive_merge.sv
module pci_drive_merge (
	input logic CLK,
	input logic rstf,
	input logic [3:0] cbe_n_i,
	pci_drive_if.merge fn0,
	pci_drive_if.merge fn1,
	output logic [31:0] ad_o,
	output logic ad_oe_o,
	output logic par_o,
	output logic par_oe_o,
	output logic trdy_n_o,
	output logic stop_n_o,
	output logic devsel_n_o,
	output logic ctl_oe_o
);
	import pci_pkg::*;

	// AD goes to the first function that enables it
	always_comb
	begin
		if (fn0.ad_oe)
			ad_o = fn0.ad;
		else if (fn1.ad_oe)
			ad_o = fn1.ad;
		else
			ad_o = '0;
		ad_oe_o = fn0.ad_oe | fn1.ad_oe;
	end

	always_comb
	begin
		if (fn0.ctl_oe)
			trdy_n_o = fn0.trdy_n;
		else if (fn1.ctl_oe)
			trdy_n_o = fn1.trdy_n;
		else
			trdy_n_o = 1'b1; // idle high
	end

	always_comb
	begin
		if (fn0.ctl_oe)
			stop_n_o = fn0.stop_n;
		else if (fn1.ctl_oe)
			stop_n_o = fn1.stop_n;
		else
			stop_n_o = 1'b1;
	end

	always_comb
	begin
		if (fn0.ctl_oe)
			devsel_n_o = fn0.devsel_n;
		else if (fn1.ctl_oe)
			devsel_n_o = fn1.devsel_n;
		else
			devsel_n_o = 1'b1;
	end

	assign ctl_oe_o = fn0.ctl_oe | fn1.ctl_oe;

	// PAR trails AD by one clock
	always_ff @(posedge CLK or negedge rstf)
	begin
		if (!rstf)
			par_oe_o <= 1'b0;
		else
			par_oe_o <= ad_oe_o;
	end

	always_ff @(posedge CLK)
	begin
		par_o <= pci_parity(ad_o, cbe_n_i);
	end

endmodule

//--- hw/pci_multi_top.sv
module pci_multi_top (
	input logic CLK,
	input logic rstf,

	// master driven
	input logic [31:0] ad_i,
	input logic [3:0] cbe_n_i,
	input logic frame_n_i,
	input logic irdy_n_i,

	// target drives
	output logic [31:0] ad_o,
	output logic ad_oe_o,
	output logic par_o,
	output logic par_oe_o,
	output logic trdy_n_o,
	output logic stop_n_o,
	output logic devsel_n_o,
	output logic ctl_oe_o
);

	pci_drive_if fn0_drv ();
	pci_drive_if fn1_drv ();

	pci_target_fn #(
		.BASE(pci_pkg::FN0_BASE)
	) fn0_i (
		.CLK(CLK),
		.rstf(rstf),
		.ad_i(ad_i),
		.cbe_n_i(cbe_n_i),
		.frame_n_i(frame_n_i),
		.irdy_n_i(irdy_n_i),
		.drv(fn0_drv.fn)
	);

	pci_target_fn #(
		.BASE(pci_pkg::FN1_BASE)
	) fn1_i (
		.CLK(CLK),
		.rstf(rstf),
		.ad_i(ad_i),
		.cbe_n_i(cbe_n_i),
		.frame_n_i(frame_n_i),
		.irdy_n_i(irdy_n_i),
		.drv(fn1_drv.fn)
	);

	// fn0 wins where both drive
	pci_drive_merge merge_i (
		.CLK(CLK),
		.rstf(rstf),
		.cbe_n_i(cbe_n_i),
		.fn0(fn0_drv.merge),
		.fn1(fn1_drv.merge),
		.ad_o(ad_o),
		.ad_oe_o(ad_oe_o),
		.par_o(par_o),
		.par_oe_o(par_oe_o),
		.trdy_n_o(trdy_n_o),
		.stop_n_o(stop_n_o),
		.devsel_n_o(devsel_n_o),
		.ctl_oe_o(ctl_oe_o)
	);

endmodule

//--- testbench/pci_multi_chk.sv
module pci_multi_chk (
	input logic CLK,
	input logic rstf,
	input logic [31:0] ad_i,
	input logic [3:0] cbe_n_i,
	input logic frame_n_i,
	input logic [31:0] ad_o,
	input logic ad_oe_o,
	input logic par_o,
	input logic par_oe_o,
	input logic trdy_n_o,
	input logic stop_n_o,
	input logic devsel_n_o,
	input logic ctl_oe_o
);
	import pci_pkg::*;

	int fail_cnt = 0; // read by the testbench at the end
	logic frame_q;
	logic addr_start;
	logic claimable;
	logic claim_q;
	int quiet_cnt; // cycles left with nothing driven

	assign addr_start = frame_q && !frame_n_i;
	assign claimable = ((ad_i[31:DEC_LSB] == FN0_BASE[31:DEC_LSB])
		|| (ad_i[31:DEC_LSB] == FN1_BASE[31:DEC_LSB]))
		&& ((cbe_n_i == CMD_MEM_READ) || (cbe_n_i == CMD_MEM_WRITE));

	always_ff @(posedge CLK or negedge rstf)
	begin
		if (!rstf)
		begin
			frame_q <= 1'b1;
			claim_q <= 1'b0;
			quiet_cnt <= 0;
		end
		else
		begin
			frame_q <= frame_n_i;
			claim_q <= addr_start && claimable;
			if (addr_start && !claimable)
				quiet_cnt <= 5; // master abort window
			else if (quiet_cnt != 0)
				quiet_cnt <= quiet_cnt - 1;
		end
	end

	task automatic count_failure(input string what);
		$error("%s", what);
		fail_cnt++;
	endtask

	a_claim: assert property (@(posedge CLK) disable iff (!rstf) claim_q |=> !devsel_n_o)
		else count_failure("hit not claimed with DEVSEL# after the second edge");
	a_quiet: assert property (@(posedge CLK) disable iff (!rstf)
		(quiet_cnt != 0) |-> (devsel_n_o && !ctl_oe_o && !ad_oe_o && !par_oe_o))
		else count_failure("target drove the bus on an unclaimed access");
	a_parity: assert property (@(posedge CLK) disable iff (!rstf)
		ad_oe_o |=> (par_oe_o && (par_o == pci_parity($past(ad_o), $past(cbe_n_i)))))
		else count_failure("PAR wrong or not driven one cycle after AD");
	a_ad_claim: assert property (@(posedge CLK) disable iff (!rstf) ad_oe_o |-> !devsel_n_o)
		else count_failure("AD driven without DEVSEL#");
	a_turn_vals: assert property (@(posedge CLK) disable iff (!rstf)
		$rose(devsel_n_o) |-> (ctl_oe_o && trdy_n_o && stop_n_o))
		else count_failure("control lines not driven high in the turnaround cycle");
	a_turn_rel: assert property (@(posedge CLK) disable iff (!rstf)
		$rose(devsel_n_o) |=> !ctl_oe_o)
		else count_failure("control lines not released after one turnaround cycle");

endmodule

bind pci_multi_top pci_multi_chk proto_chk (.*);

//--- testbench/tb_pci_master.svh
`ifndef TB_PCI_MASTER_SVH
`define TB_PCI_MASTER_SVH

// all tasks start and end 1 unit after a rising edge
task automatic wait_cycles(input int n);
	repeat (n)
	begin
		@(posedge CLK);
		#1;
	end
endtask

task automatic release_bus();
	frame_n_i = 1'b1;
	irdy_n_i = 1'b1;
	ad_i = '0;
	cbe_n_i = '1;
endtask

task automatic drive_addr(input logic [31:0] addr, input logic [3:0] cmd);
	frame_n_i = 1'b0;
	ad_i = addr;
	cbe_n_i = cmd;
	wait_cycles(1);
endtask

// first data phase, returns just after the transfer edge
task automatic data_phase(input logic [31:0] data, input logic [3:0] be_n, input logic burst,
	output logic [31:0] rd, output logic stop_seen);
	int delay;
	delay = $urandom_range(3, 0);
	frame_n_i = !burst;
	ad_i = data;
	cbe_n_i = be_n;
	irdy_n_i = (delay != 0);
	while (irdy_n_i || trdy_n_o)
	begin
		wait_cycles(1);
		if (delay > 0)
			delay--;
		irdy_n_i = (delay != 0);
	end
	rd = ad_o; // stable until the transfer edge
	stop_seen = !stop_n_o;
	wait_cycles(1);
endtask

task automatic finish_access();
	release_bus();
	while (!devsel_n_o)
		wait_cycles(1);
	wait_cycles(2);
endtask

task automatic mem_write(input logic [31:0] addr, input logic [31:0] data,
	input logic [3:0] be_n);
	logic [31:0] rd;
	logic stop_seen;
	drive_addr(addr, CMD_MEM_WRITE);
	data_phase(data, be_n, 1'b0, rd, stop_seen);
	finish_access();
endtask

task automatic mem_read(input logic [31:0] addr, output logic [31:0] data);
	logic stop_seen;
	drive_addr(addr, CMD_MEM_READ);
	data_phase('0, 4'b0000, 1'b0, data, stop_seen);
	finish_access();
endtask

task automatic burst_write(input logic [31:0] addr, input logic [31:0] d0,
	input logic [31:0] d1, output logic stop_seen);
	logic [31:0] rd;
	drive_addr(addr, CMD_MEM_WRITE);
	data_phase(d0, 4'b0000, 1'b1, rd, stop_seen);
	ad_i = d1; // second word, IRDY# still low
	repeat (2)
	begin
		if (!trdy_n_o)
			report_fault("burst: target accepted a second data phase");
		if (devsel_n_o)
			report_fault("burst: DEVSEL# released while FRAME# still low");
		wait_cycles(1);
	end
	finish_access();
endtask

task automatic unclaimed_access(input logic [31:0] addr, input logic [3:0] cmd);
	drive_addr(addr, cmd);
	frame_n_i = 1'b1;
	irdy_n_i = 1'b0;
	wait_cycles(5); // master abort
	release_bus();
	wait_cycles(2);
endtask

`endif

//--- testbench/tb_pci_multi.sv
module tb_pci_multi;
	import pci_pkg::*;

	localparam int NUM_WRITES = 16;
	localparam int NUM_ACCESSES = 40;

	logic CLK;
	logic rstf;
	logic [31:0] ad_i;
	logic [3:0] cbe_n_i;
	logic frame_n_i;
	logic irdy_n_i;
	logic [31:0] ad_o;
	logic ad_oe_o;
	logic par_o;
	logic par_oe_o;
	logic trdy_n_o;
	logic stop_n_o;
	logic devsel_n_o;
	logic ctl_oe_o;

	logic [31:0] shadow [2][REG_WORDS]; // expected register contents
	int data_errs = 0;
	int proto_errs = 0;

	pci_multi_top UUT (
		.CLK(CLK),
		.rstf(rstf),
		.ad_i(ad_i),
		.cbe_n_i(cbe_n_i),
		.frame_n_i(frame_n_i),
		.irdy_n_i(irdy_n_i),
		.ad_o(ad_o),
		.ad_oe_o(ad_oe_o),
		.par_o(par_o),
		.par_oe_o(par_oe_o),
		.trdy_n_o(trdy_n_o),
		.stop_n_o(stop_n_o),
		.devsel_n_o(devsel_n_o),
		.ctl_oe_o(ctl_oe_o)
	);

	`include "tb_pci_master.svh"

	task automatic report_mismatch(input string test, input logic [31:0] exp,
		input logic [31:0] act);
		data_errs++;
		$display("** Error: %s: expected %08h, actual %08h", test, exp, act);
	endtask

	task automatic report_fault(input string what);
		proto_errs++;
		$display("%s (time %0t)", what, $time);
	endtask

	function automatic logic [31:0] reg_addr(input int fn, input int idx);
		logic [31:0] base;
		base = (fn == 0) ? FN0_BASE : FN1_BASE;
		return base + (idx << REG_IDX_LSB);
	endfunction

	task automatic check_all_regs(input string test);
		logic [31:0] rd;
		for (int f = 0; f < 2; f++)
			for (int i = 0; i < REG_WORDS; i++)
			begin
				mem_read(reg_addr(f, i), rd);
				if (rd !== shadow[f][i])
					report_mismatch(test, shadow[f][i], rd);
			end
	endtask

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	initial
	begin
		#((NUM_ACCESSES * 12 + 50) * 8);
		$display("timeout: the test sequence did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		logic [31:0] r;
		logic [31:0] data;
		logic [31:0] rd;
		logic stop_seen;
		int fn;
		int idx;
		int total;
		r = $urandom(32'heac4997f);
		rstf = 1'b0;
		release_bus();
		for (int f = 0; f < 2; f++)
			for (int i = 0; i < REG_WORDS; i++)
				shadow[f][i] = '0;
		repeat (2) @(posedge CLK);
		#1 rstf = 1'b1;
		wait_cycles(2);

		check_all_regs("reset_value");

		for (int n = 0; n < NUM_WRITES; n++)
		begin
			fn = $urandom_range(1, 0);
			idx = $urandom_range(REG_WORDS - 1, 0);
			data = $urandom;
			r = $urandom;
			mem_write(reg_addr(fn, idx), data, r[3:0]);
			for (int b = 0; b < 4; b++)
				if (!r[b])
					shadow[fn][idx][8*b +: 8] = data[8*b +: 8];
		end
		check_all_regs("byte_write");

		// outside both windows, then wrong commands
		unclaimed_access(FN1_BASE + 32'h10, CMD_MEM_READ);
		unclaimed_access(32'h4000_0004, CMD_MEM_WRITE);
		unclaimed_access(FN0_BASE, 4'b0010);
		unclaimed_access(FN1_BASE + 32'h4, 4'b1011);

		data = $urandom;
		burst_write(reg_addr(0, REG_WORDS - 1), data, ~data, stop_seen);
		shadow[0][REG_WORDS - 1] = data;
		if (!stop_seen)
			report_fault("burst: STOP# not asserted together with TRDY#");
		mem_read(reg_addr(0, REG_WORDS - 1), rd);
		if (rd !== shadow[0][REG_WORDS - 1])
			report_mismatch("burst_first_word", shadow[0][REG_WORDS - 1], rd);
		mem_read(reg_addr(1, 0), rd);
		if (rd !== shadow[1][0])
			report_mismatch("burst_next_fn", shadow[1][0], rd);

		wait_cycles(4);
		total = data_errs + proto_errs + UUT.proto_chk.fail_cnt;
		$display("errors: %0d data, %0d protocol, %0d assertion", data_errs, proto_errs,
			UUT.proto_chk.fail_cnt);
		if (total == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- compile.f
+incdir+testbench
hw/pci_pkg.sv
hw/pci_drive_if.sv
hw/pci_target_fn.sv
hw/pci_drive_merge.sv
hw/pci_multi_top.sv
testbench/pci_multi_chk.sv
testbench/tb_pci_multi.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_pci_multi -f compile.f -o vsim \
	&& ./obj_dir/vsim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && echo "FAIL" && exit 1
echo "PASS"
exit 0
